//--- verilog/wbuf_pkg.sv
package wbuf_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////////////////////////

  // Data and address width
  localparam int xlen       = 32;

  // Queue entries, power of two
  localparam int wbuf_depth = 8;

  // Fill pointer width
  localparam int wbuf_aw    = 3;

  // Words in the memory section
  localparam int mem_words  = 256;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  // Privilege level, machine mode highest
  typedef enum logic [1:0] {
    prv_u = 2'b00,
    prv_s = 2'b01,
    prv_h = 2'b10,
    prv_m = 2'b11
  } prv_e;

  // One access as it travels through the queue
  typedef struct packed {
    logic [xlen-1:0]   adr;
    logic [xlen-1:0]   d;
    logic [xlen/8-1:0] be;
    logic              we;
    prv_e              prv;
    // Flush request, ordered behind earlier writes
    logic              flush;
  } mem_req_t;

  // Memory section FSM
  typedef enum logic [1:0] {
    dmem_idle,
    dmem_wait,
    dmem_flush
  } dmem_state_e;

endpackage

//--- verilog/wbuf_fifo.sv
`timescale 1ns/10ps

module wbuf_fifo (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 push,
  input  wbuf_pkg::mem_req_t   push_data,
  input  logic                 pop,
  output wbuf_pkg::mem_req_t   head,
  output logic                 empty,
  output logic                 full
);

  // Entry 0 is the head, entries shift toward it on pop
  wbuf_pkg::mem_req_t               q [wbuf_pkg::wbuf_depth];

  // Next free slot, wraps to 0 when the queue is full
  logic [wbuf_pkg::wbuf_aw-1:0]     wptr;
  logic [wbuf_pkg::wbuf_aw-1:0]     wptr_m1;

  // Slot below the fill pointer, used when push and pop coincide
  assign wptr_m1 = wptr - 1'b1;

  assign head = q[0];

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // Shift toward the head
    if (pop) begin
      for (int i = 0; i < wbuf_pkg::wbuf_depth - 1; i++) begin
        q[i] <= q[i+1];
      end
    end
    // New entry lands one lower if the queue shifts as well
    if (push) begin
      if (pop) begin
        q[wptr_m1] <= push_data;
      end else begin
        q[wptr] <= push_data;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Fill pointer and flags
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wptr  <= '0;
      empty <= 1'b1;
      full  <= 1'b0;
    end else begin
      case ({push, pop})
        2'b10: begin
          wptr  <= wptr + 1'b1;
          empty <= 1'b0;
          // Last free slot taken
          full  <= &wptr;
        end
        2'b01: begin
          wptr  <= wptr_m1;
          full  <= 1'b0;
          // Only one entry was left
          empty <= (wptr == wbuf_pkg::wbuf_aw'(1));
        end
        // Push with pop keeps the level
        default: ;
      endcase
    end
  end

endmodule

//--- verilog/wbuf.sv
`timescale 1ns/10ps

module wbuf (
  input  logic                        clk,
  input  logic                        rstn,
  // CPU side
  input  logic                        cpu_valid,
  input  wbuf_pkg::mem_req_t          cpu_req,
  output logic [wbuf_pkg::xlen-1:0]   cpu_q,
  output logic                        cpu_ack,
  // Memory section side
  output logic                        mem_req,
  output wbuf_pkg::mem_req_t          mem_cmd,
  input  logic [wbuf_pkg::xlen-1:0]   mem_q,
  input  logic                        mem_ack
);

  logic                  fifo_push;
  logic                  fifo_pop;
  logic                  fifo_empty;
  logic                  fifo_full;
  wbuf_pkg::mem_req_t    fifo_head;

  // One access at the memory section
  logic                  access_pending;
  // Outstanding access is a write, its memory ack stays here
  logic                  out_we;
  // Write strobe seen last cycle
  logic                  we_ack;
  // Write ack withheld by a full queue
  logic                  ack_held;

  //////////////////////////////////////////////////////////////////////
  // Queue
  //////////////////////////////////////////////////////////////////////

  // Queue the access unless it can go straight out on this ack
  assign fifo_push = access_pending & cpu_valid & ~(fifo_empty & mem_ack);

  // Head retires as it is issued
  assign fifo_pop  = mem_ack & ~fifo_empty;

  wbuf_fifo fifo0 (
    .clk       (clk),
    .rstn      (rstn),
    .push      (fifo_push),
    .push_data (cpu_req),
    .pop       (fifo_pop),
    .head      (fifo_head),
    .empty     (fifo_empty),
    .full      (fifo_full)
  );

  //////////////////////////////////////////////////////////////////////
  // Memory request
  //////////////////////////////////////////////////////////////////////

  // Idle memory takes the CPU access at once
  // Busy memory takes the next one on its ack
  assign mem_req = access_pending ? (mem_ack & (cpu_valid | ~fifo_empty))
                                  : cpu_valid;

  // Head first, bypass when nothing is queued
  assign mem_cmd = fifo_empty ? cpu_req : fifo_head;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      access_pending <= 1'b0;
      out_we         <= 1'b0;
    end else begin
      access_pending <= mem_req | (access_pending & ~mem_ack);
      if (mem_req) begin
        out_we <= mem_cmd.we;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // CPU acknowledge
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      we_ack   <= 1'b0;
      ack_held <= 1'b0;
    end else begin
      we_ack <= cpu_valid & cpu_req.we;
      // Held until a slot frees up
      if (fifo_pop) begin
        ack_held <= 1'b0;
      end else if (we_ack & fifo_full) begin
        ack_held <= 1'b1;
      end
    end
  end

  // Immediate write ack, full queue release, read or flush completion
  assign cpu_ack = (we_ack & ~fifo_full) |
                   (fifo_full & fifo_pop & (we_ack | ack_held)) |
                   (mem_ack & ~out_we);

  // Read data straight from memory, valid with cpu_ack
  assign cpu_q = mem_q;

endmodule

//--- verilog/dmem_ctrl.sv
`timescale 1ns/10ps

module dmem_ctrl (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        mem_req,
  input  wbuf_pkg::mem_req_t          mem_cmd,
  output logic [wbuf_pkg::xlen-1:0]   mem_q,
  output logic                        mem_ack,
  output logic                        flush_done
);

  wbuf_pkg::dmem_state_e                     state;
  wbuf_pkg::mem_req_t                        cmd_r;
  logic [2:0]                                wait_cnt;
  logic [wbuf_pkg::xlen-1:0]                 store [wbuf_pkg::mem_words];
  logic [$clog2(wbuf_pkg::mem_words)-1:0]    widx;
  logic                                      acc_done;
  logic                                      flush_end;
  logic                                      prv_drop;

  // Word index from the latched address
  assign widx = cmd_r.adr[9:2];

  assign acc_done  = (state == wbuf_pkg::dmem_wait)  && (wait_cnt == 3'd0);
  assign flush_end = (state == wbuf_pkg::dmem_flush) && (wait_cnt == 3'd0);

  // User mode may not write the upper half
  assign prv_drop = (cmd_r.prv == wbuf_pkg::prv_u) & cmd_r.adr[31];

  //////////////////////////////////////////////////////////////////////
  // FSM and wait states
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state      <= wbuf_pkg::dmem_idle;
      wait_cnt   <= 3'd0;
      mem_ack    <= 1'b0;
      flush_done <= 1'b0;
    end else begin
      mem_ack    <= 1'b0;
      flush_done <= 1'b0;
      case (state)
        wbuf_pkg::dmem_idle: begin
          if (mem_req) begin
            // Eight cycles of drain, else one to four by address
            if (mem_cmd.flush) begin
              wait_cnt <= 3'd7;
              state    <= wbuf_pkg::dmem_flush;
            end else begin
              wait_cnt <= {1'b0, mem_cmd.adr[3:2]};
              state    <= wbuf_pkg::dmem_wait;
            end
          end
        end
        wbuf_pkg::dmem_wait: begin
          if (acc_done) begin
            mem_ack <= 1'b1;
            state   <= wbuf_pkg::dmem_idle;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        wbuf_pkg::dmem_flush: begin
          // Ack and done pulse together
          if (flush_end) begin
            mem_ack    <= 1'b1;
            flush_done <= 1'b1;
            state      <= wbuf_pkg::dmem_idle;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        default: state <= wbuf_pkg::dmem_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Word store
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if ((state == wbuf_pkg::dmem_idle) && mem_req) begin
      cmd_r <= mem_cmd;
    end
    if (acc_done) begin
      if (cmd_r.we) begin
        // Merge enabled bytes, dropped writes still get their ack
        if (!prv_drop) begin
          for (int b = 0; b < wbuf_pkg::xlen / 8; b++) begin
            if (cmd_r.be[b]) store[widx][8*b +: 8] <= cmd_r.d[8*b +: 8];
          end
        end
      end else begin
        mem_q <= store[widx];
      end
    end
  end

endmodule

//--- verilog/dmem_subsys_top.sv
`timescale 1ns/10ps

module dmem_subsys_top (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        cpu_valid,
  input  wbuf_pkg::mem_req_t          cpu_req,
  output logic [wbuf_pkg::xlen-1:0]   cpu_q,
  output logic                        cpu_ack,
  output logic                        flush_done
);

  //////////////////////////////////////////////////////////////////////
  // Buffer to memory section
  //////////////////////////////////////////////////////////////////////

  logic                         mem_req;
  wbuf_pkg::mem_req_t           mem_cmd;
  logic [wbuf_pkg::xlen-1:0]    mem_q;
  logic                         mem_ack;

  // Write buffer, acks writes early
  wbuf wbuf0 (
    .clk       (clk),
    .rstn      (rstn),
    .cpu_valid (cpu_valid),
    .cpu_req   (cpu_req),
    .cpu_q     (cpu_q),
    .cpu_ack   (cpu_ack),
    .mem_req   (mem_req),
    .mem_cmd   (mem_cmd),
    .mem_q     (mem_q),
    .mem_ack   (mem_ack)
  );

  // Slow word store behind it
  dmem_ctrl dmem0 (
    .clk        (clk),
    .rstn       (rstn),
    .mem_req    (mem_req),
    .mem_cmd    (mem_cmd),
    .mem_q      (mem_q),
    .mem_ack    (mem_ack),
    .flush_done (flush_done)
  );

endmodule

//--- testbench/wbuf_sva.sv
`timescale 1ns/10ps

module wbuf_sva (
  input logic clk,
  input logic rstn,
  input logic cpu_valid,
  input logic cpu_ack,
  input logic mem_req,
  input logic mem_ack,
  input logic fifo_push,
  input logic fifo_pop,
  input logic fifo_empty,
  input logic fifo_full
);

  // CPU access waiting for its ack
  logic                         cpu_busy;
  // Queue level counted from push and pop
  logic [wbuf_pkg::wbuf_aw:0]   fill_lvl;
  // Memory requests still waiting for mem_ack
  logic [1:0]                   mem_out;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cpu_busy <= 1'b0;
    end else if (cpu_valid) begin
      cpu_busy <= 1'b1;
    end else if (cpu_ack) begin
      cpu_busy <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      fill_lvl <= '0;
    end else begin
      case ({fifo_push, fifo_pop})
        2'b10:   fill_lvl <= fill_lvl + 1'b1;
        2'b01:   fill_lvl <= fill_lvl - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mem_out <= 2'd0;
    end else if (mem_req && !mem_ack) begin
      mem_out <= mem_out + 1'b1;
    end else if (mem_ack && !mem_req) begin
      mem_out <= mem_out - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Queue flags
  //////////////////////////////////////////////////////////////////////

  // Flags follow the level and are never both set
  a_flags: assert property (@(posedge clk) disable iff (!rstn)
    (fifo_empty == (fill_lvl == '0)) &&
    (fifo_full == (int'(fill_lvl) == wbuf_pkg::wbuf_depth)))
    else $error("Queue flags disagree with the queue level");

  // Full queue only takes an entry while the head leaves
  a_push_full: assert property (@(posedge clk) disable iff (!rstn)
    (fifo_full && fifo_push) |-> fifo_pop)
    else $error("Push into a full queue without a pop");

  //////////////////////////////////////////////////////////////////////
  // Memory and CPU handshakes
  //////////////////////////////////////////////////////////////////////

  // Next request only on the ack of the one before
  a_one_out: assert property (@(posedge clk) disable iff (!rstn)
    (mem_req && (mem_out != 2'd0)) |-> mem_ack)
    else $error("New memory request while one is still outstanding");

  a_ack_busy: assert property (@(posedge clk) disable iff (!rstn)
    cpu_ack |-> cpu_busy)
    else $error("CPU ack without an outstanding CPU access");

endmodule

bind wbuf wbuf_sva sva0 (
  .clk            (clk),
  .rstn           (rstn),
  .cpu_valid      (cpu_valid),
  .cpu_ack        (cpu_ack),
  .mem_req        (mem_req),
  .mem_ack        (mem_ack),
  .fifo_push      (fifo_push),
  .fifo_pop       (fifo_pop),
  .fifo_empty     (fifo_empty),
  .fifo_full      (fifo_full)
);

//--- testbench/tb_top.sv
`timescale 1ns/10ps

module tb_top;

  // Seed, wait limit and burst sizes
  localparam logic [31:0] seed        = 32'h7edc;
  localparam int          ack_timeout = 200;
  localparam int          burst_len   = 20;
  localparam int          fill_words  = 8;

  logic                        clk = 1'b0;
  logic                        rstn;
  logic                        cpu_valid;
  wbuf_pkg::mem_req_t          cpu_req;
  logic [wbuf_pkg::xlen-1:0]   cpu_q;
  logic                        cpu_ack;
  logic                        flush_done;

  // Shadow of the word store
  logic [wbuf_pkg::xlen-1:0]   shadow [wbuf_pkg::mem_words];
  // Expected read data, armed when a read goes out
  logic [wbuf_pkg::xlen-1:0]   exp_q;
  logic                        chk_read;
  logic [31:0]                 rng;
  int                          cmp_err   = 0;
  int                          tb_err    = 0;
  int                          flush_cnt = 0;
  int                          pass_cnt  = 0;
  int                          fail_cnt  = 0;
  int                          test_num  = 0;

  dmem_subsys_top dut0 (
    .clk        (clk),
    .rstn       (rstn),
    .cpu_valid  (cpu_valid),
    .cpu_req    (cpu_req),
    .cpu_q      (cpu_q),
    .cpu_ack    (cpu_ack),
    .flush_done (flush_done)
  );

  // 8 ns period
  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Byte merge, user writes to the upper half are dropped
  function automatic logic [31:0] exp_word(input logic [31:0] old,
                                           input wbuf_pkg::mem_req_t r);
    logic [31:0] w;
    w = old;
    if (!((r.prv == wbuf_pkg::prv_u) && r.adr[31])) begin
      for (int b = 0; b < 4; b++) begin
        if (r.be[b]) w[8*b +: 8] = r.d[8*b +: 8];
      end
    end
    return w;
  endfunction

  function automatic wbuf_pkg::mem_req_t make_req(input logic [31:0] adr,
      input logic [31:0] d, input logic [3:0] be, input logic we,
      input wbuf_pkg::prv_e prv, input logic flush);
    wbuf_pkg::mem_req_t r;
    r.adr   = adr;
    r.d     = d;
    r.be    = be;
    r.we    = we;
    r.prv   = prv;
    r.flush = flush;
    return r;
  endfunction

  function automatic int err_total();
    return cmp_err + tb_err;
  endfunction

  // One strobe, then wait for the ack
  task automatic issue(input wbuf_pkg::mem_req_t r);
    logic [7:0] idx;
    int         n;
    idx = r.adr[9:2];
    n   = 0;
    @(posedge clk);
    // Shadow updates in issue order like the memory
    if (r.we) begin
      shadow[idx] = exp_word(shadow[idx], r);
      chk_read    = 1'b0;
    end else begin
      exp_q    = shadow[idx];
      chk_read = ~r.flush;
    end
    cpu_valid <= 1'b1;
    cpu_req   <= r;
    @(posedge clk);
    cpu_valid <= 1'b0;
    @(negedge clk);
    while (!cpu_ack && n < ack_timeout) begin
      @(negedge clk);
      n++;
    end
    assert (cpu_ack) else begin
      $display("Access to %h got no cpu_ack within %0d cycles", r.adr, ack_timeout);
      tb_err++;
    end
    // Flush ack and done pulse share a cycle
    if (cpu_ack && r.flush) begin
      assert (flush_done) else begin
        $display("ERROR: %0t flush_done expected 1 got %b", $time, flush_done);
        tb_err++;
      end
    end
  endtask

  task automatic write_word(input logic [31:0] adr, input logic [31:0] d,
                            input logic [3:0] be, input wbuf_pkg::prv_e prv);
    issue(make_req(adr, d, be, 1'b1, prv, 1'b0));
  endtask

  task automatic read_word(input logic [31:0] adr);
    issue(make_req(adr, 32'h0, 4'h0, 1'b0, wbuf_pkg::prv_m, 1'b0));
  endtask

  task automatic flush_mem();
    int cnt0;
    cnt0 = flush_cnt;
    issue(make_req(32'h0, 32'h0, 4'h0, 1'b0, wbuf_pkg::prv_m, 1'b1));
    // Idle gap catches any extra pulse
    repeat (4) @(posedge clk);
    assert (flush_cnt == cnt0 + 1) else begin
      $display("ERROR: %0t flush_done pulses expected 1 got %0d", $time, flush_cnt - cnt0);
      tb_err++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    @(posedge clk);
    test_num++;
    if (err_total() == errs_before) begin
      pass_cnt++;
      $display("Test %0d %s: PASS", test_num, name);
    end else begin
      fail_cnt++;
      $display("Test %0d %s: FAIL", test_num, name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Read data check and flush pulse count
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rstn && cpu_ack && chk_read) begin
      assert (cpu_q == exp_q) else begin
        $display("ERROR: %0t cpu_q expected %h got %h", $time, exp_q, cpu_q);
        cmp_err++;
      end
    end
  end

  always @(negedge clk) begin
    if (rstn && flush_done) flush_cnt++;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          errs;
    logic [31:0] r;
    logic [31:0] adr;
    rng       = seed;
    rstn      = 1'b0;
    cpu_valid = 1'b0;
    cpu_req   = '0;
    exp_q     = '0;
    chk_read  = 1'b0;
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);

    errs = err_total();
    write_word(32'h0000_0010, 32'hcafe_f00d, 4'hf, wbuf_pkg::prv_m);
    read_word(32'h0000_0010);
    end_test("write then read back", errs);

    // Word 9, two wait states
    errs = err_total();
    write_word(32'h0000_0024, 32'h1122_3344, 4'hf, wbuf_pkg::prv_m);
    write_word(32'h0000_0024, 32'haaaa_aaaa, 4'h1, wbuf_pkg::prv_m);
    write_word(32'h0000_0024, 32'hbbbb_bbbb, 4'h4, wbuf_pkg::prv_m);
    write_word(32'h0000_0024, 32'hcccc_cccc, 4'ha, wbuf_pkg::prv_s);
    read_word(32'h0000_0024);
    end_test("byte enable merge", errs);

    // Full words first so that no byte stays undefined
    errs = err_total();
    for (int i = 0; i < fill_words; i++) begin
      rng = xorshift(rng);
      write_word(32'h100 + i * 4, rng, 4'hf, wbuf_pkg::prv_m);
    end
    for (int i = 0; i < burst_len; i++) begin
      rng = xorshift(rng);
      r   = rng;
      rng = xorshift(rng);
      adr = 32'h100 | {27'd0, r[2:0], 2'b00};
      adr[31] = r[3];
      write_word(adr, rng, r[9:6], wbuf_pkg::prv_e'(r[5:4]));
    end
    for (int i = 0; i < fill_words; i++) begin
      read_word(32'h100 + i * 4);
    end
    end_test("buffer fill", errs);

    // Slowest word, the read queues behind both writes
    errs = err_total();
    write_word(32'h0000_002c, 32'h0123_4567, 4'hf, wbuf_pkg::prv_m);
    write_word(32'h0000_002c, 32'h89ab_cdef, 4'hf, wbuf_pkg::prv_m);
    write_word(32'h0000_002c, 32'h5a5a_0000, 4'hc, wbuf_pkg::prv_m);
    read_word(32'h0000_002c);
    end_test("read after buffered writes", errs);

    errs = err_total();
    write_word(32'h8000_0030, 32'h600d_0001, 4'hf, wbuf_pkg::prv_m);
    write_word(32'h8000_0030, 32'hbad0_0002, 4'hf, wbuf_pkg::prv_u);
    read_word(32'h8000_0030);
    write_word(32'h8000_0030, 32'h600d_0003, 4'h3, wbuf_pkg::prv_m);
    read_word(32'h8000_0030);
    end_test("privilege protection", errs);

    errs = err_total();
    for (int k = 0; k < 2; k++) begin
      write_word(32'h0000_0050, 32'h0f0f_0000 + k, 4'hf, wbuf_pkg::prv_m);
      write_word(32'h0000_0054, 32'h7070_0000 + k, 4'hf, wbuf_pkg::prv_m);
      flush_mem();
      read_word(32'h0000_0050);
    end
    end_test("flush ordering", errs);

    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_total() == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- sim.f
verilog/wbuf_pkg.sv
verilog/wbuf_fifo.sv
verilog/wbuf.sv
verilog/dmem_ctrl.sv
verilog/dmem_subsys_top.sv
testbench/wbuf_sva.sv
testbench/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the write buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_top -Mdir obj_dir -o tb_top -f sim.f > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
  cat build.log
  echo "Verilator build exited with status $build_status"
  exit 1
fi

./obj_dir/tb_top > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Regression passed" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1
